/* Bender.yml */
package:
  name: conv_store

sources:
  - files:
      - verilog/conv_store_pkg.sv
      - verilog/store_sequencer.sv
      - verilog/store_loop_counter.sv
      - verilog/row_fifo_bank.sv
      - verilog/store_output_stage.sv
      - verilog/conv_store_top.sv

  - target: test
    files:
      - verif/tb_conv_store.sv

/* src.f */
verilog/conv_store_pkg.sv
verilog/store_sequencer.sv
verilog/store_loop_counter.sv
verilog/row_fifo_bank.sv
verilog/store_output_stage.sv
verilog/conv_store_top.sv
verif/tb_conv_store.sv

/* verif/tb_conv_store.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_conv_store;

  localparam int column_num  = 4;
  localparam int pixel_width = 8;
  // one full channel block per fifo fits ahead of the run
  localparam int fifo_depth  = 16;
  localparam int iw          = conv_store_pkg::idx_width;
  localparam int nf          = conv_store_pkg::fifo_count;
  localparam int sel_width   = $clog2(nf);
  localparam int word_width  = pixel_width * 4 * column_num;
  localparam int out_width   = pixel_width * 2 * column_num;
  localparam int num_rows    = 5;
  localparam int max_words   = 512;
  localparam int period      = 100;

  logic                  clk;
  logic                  reset;
  logic                  mode_init;
  logic [iw-1:0]         cur_ox_start;
  logic [iw-1:0]         cur_oy_start;
  logic [iw-1:0]         cur_of_start;
  logic [iw-1:0]         cur_pof;
  logic [iw-1:0]         cur_poy;
  logic                  conv_store_start;
  logic                  fifo_wr_en;
  logic [sel_width-1:0]  fifo_wr_sel;
  logic [word_width-1:0] fifo_wr_data;
  logic                  out_valid;
  logic [iw-1:0]         out_y_idx;
  logic [iw-1:0]         out_x_idx;
  logic [iw-1:0]         out_f_idx;
  logic [sel_width-1:0]  fifo_row_no;
  logic [sel_width-1:0]  fifo_column_no;
  logic [out_width-1:0]  out_data;
  logic                  tile_end;
  logic                  busy;

  //////////////////////////////////////////////////////////////////////
  // test table, one tile per row
  //////////////////////////////////////////////////////////////////////

  conv_store_pkg::store_mode_e tbl_mode [num_rows] = '{conv_store_pkg::mode_88,
    conv_store_pkg::mode_18, conv_store_pkg::mode_88, conv_store_pkg::mode_18,
    conv_store_pkg::mode_18};
  int            tbl_poy      [num_rows] = '{3, 2, 1, 3, 1};
  int            tbl_pof      [num_rows] = '{40, 45, 5, 64, 1};
  logic [iw-1:0] tbl_ox_start [num_rows] = '{16'd3, 16'd7, 16'd0, 16'd12, 16'd1};
  logic [iw-1:0] tbl_oy_start [num_rows] = '{16'd1, 16'd5, 16'd0, 16'd9, 16'd1};
  logic [iw-1:0] tbl_of_start [num_rows] = '{16'd1, 16'd33, 16'd2, 16'd65, 16'd1};
  // words out, and tile_end offset in cycles from the start edge
  int            tbl_words    [num_rows] = '{120, 90, 5, 192, 1};
  int            tbl_tile_off [num_rows] = '{122, 92, 7, 194, 3};

  // expected stream of the current row
  logic [out_width-1:0] exp_data [max_words];
  logic [iw-1:0]        exp_y    [max_words];
  logic [iw-1:0]        exp_f    [max_words];
  logic [iw-1:0]        exp_row  [max_words];
  logic [iw-1:0]        exp_col  [max_words];
  logic                 exp_pop  [max_words];
  int                   model_count [nf];
  int                   step_total;
  int                   errors;

  conv_store_top
  #(
    .column_num  (column_num),
    .pixel_width (pixel_width),
    .fifo_depth  (fifo_depth)
  ) conv_store_top_inst
  (
    .clk              (clk),
    .reset            (reset),
    .mode_init        (mode_init),
    .cur_ox_start     (cur_ox_start),
    .cur_oy_start     (cur_oy_start),
    .cur_of_start     (cur_of_start),
    .cur_pof          (cur_pof),
    .cur_poy          (cur_poy),
    .conv_store_start (conv_store_start),
    .fifo_wr_en       (fifo_wr_en),
    .fifo_wr_sel      (fifo_wr_sel),
    .fifo_wr_data     (fifo_wr_data),
    .out_valid        (out_valid),
    .out_y_idx        (out_y_idx),
    .out_x_idx        (out_x_idx),
    .out_f_idx        (out_f_idx),
    .fifo_row_no      (fifo_row_no),
    .fifo_column_no   (fifo_column_no),
    .out_data         (out_data),
    .tile_end         (tile_end),
    .busy             (busy)
  );

  initial
  begin
    clk = 1'b0;
    forever #(period / 2) clk = ~clk;
  end

  //////////////////////////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////////////////////////

  task automatic report_failure();
    errors++;
    $display("Finished with errors");
    $fatal(1);
  endtask

  task automatic compare_idx(input string name, input logic [iw-1:0] got,
                             input logic [iw-1:0] exp);
    if (got !== exp)
    begin
      $display("Error: %s got %h expected %h", name, got, exp);
      report_failure();
    end
  endtask

  task automatic compare_data(input string name, input logic [out_width-1:0] got,
                              input logic [out_width-1:0] exp);
    if (got !== exp)
    begin
      $display("Error: %s got %h expected %h", name, got, exp);
      report_failure();
    end
  endtask

  task automatic compare_mode(input string name, input conv_store_pkg::store_mode_e got,
                              input conv_store_pkg::store_mode_e exp);
    if (got !== exp)
    begin
      $display("Error: %s got %h expected %h", name, got, exp);
      report_failure();
    end
  endtask

  task automatic compare_pulse(input string name, input logic got, input logic exp);
    if (got !== exp)
    begin
      $display("Error: %s got %h expected %h", name, got, exp);
      report_failure();
    end
  endtask

  function automatic logic [word_width-1:0] random_word();
    logic [word_width-1:0] w;
    for (int j = 0; j < word_width / 32; j++)
      w[j*32 +: 32] = $urandom();
    return w;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // loop model, fills the fifos in pop order
  //////////////////////////////////////////////////////////////////////

  task automatic build_and_fill(input int r);
    int                    blk;
    int                    fifo;
    logic [word_width-1:0] word;
    blk = (tbl_mode[r] == conv_store_pkg::mode_88) ? 16 : 32;
    step_total = 0;
    word = '0;
    for (int i = 0; i < nf; i++)
      model_count[i] = 0;
    for (int oy = 1; oy <= tbl_poy[r]; oy++)
    begin
      for (int of_pos = 1; of_pos <= tbl_pof[r]; of_pos += blk)
      begin
        for (int ch = 1; ch <= blk && of_pos - 1 + ch <= tbl_pof[r]; ch++)
        begin
          fifo = (oy - 1) * conv_store_pkg::sa_grid_rows + (of_pos - 1) / blk;
          exp_pop[step_total] = (tbl_mode[r] == conv_store_pkg::mode_88) || (ch % 2 == 1);
          if (exp_pop[step_total])
          begin
            word = random_word();
            model_count[fifo]++;
            if (model_count[fifo] > fifo_depth)
            begin
              $display("row %0d needs more words in fifo %0d than it holds", r, fifo);
              report_failure();
            end
            @(posedge clk);
            fifo_wr_en   <= 1'b1;
            fifo_wr_sel  <= sel_width'(fifo);
            fifo_wr_data <= word;
          end
          // 1x8 even step reuses the word of the odd step before it
          exp_data[step_total] = exp_pop[step_total] ? word[out_width-1:0] :
                                 word[word_width-1:out_width];
          exp_y[step_total]    = iw'(tbl_oy_start[r] - 1 + oy);
          exp_f[step_total]    = iw'(tbl_of_start[r] - 2 + of_pos + ch);
          exp_row[step_total]  = iw'((of_pos - 1) / blk);
          exp_col[step_total]  = iw'(oy - 1);
          step_total++;
        end
      end
    end
    @(posedge clk);
    fifo_wr_en <= 1'b0;
  endtask

  task automatic check_word(input int r, input int k);
    compare_data("out_data", out_data, exp_data[k]);
    compare_idx("out_y_idx", out_y_idx, exp_y[k]);
    compare_idx("out_x_idx", out_x_idx, tbl_ox_start[r]);
    compare_idx("out_f_idx", out_f_idx, exp_f[k]);
    compare_idx("fifo_row_no", iw'(fifo_row_no), exp_row[k]);
    compare_idx("fifo_column_no", iw'(fifo_column_no), exp_col[k]);
  endtask

  task automatic run_row(input int r);
    int   k;
    logic exp_valid;
    // mode is only latched while reset is high
    @(posedge clk);
    reset        <= 1'b1;
    mode_init    <= tbl_mode[r];
    cur_ox_start <= tbl_ox_start[r];
    cur_oy_start <= tbl_oy_start[r];
    cur_of_start <= tbl_of_start[r];
    cur_pof      <= iw'(tbl_pof[r]);
    cur_poy      <= iw'(tbl_poy[r]);
    repeat (4) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    compare_mode("mode", conv_store_top_inst.mode, tbl_mode[r]);
    compare_pulse("out_valid", out_valid, 1'b0);
    compare_pulse("tile_end", tile_end, 1'b0);
    compare_pulse("busy", busy, 1'b0);
    compare_idx("out_y_idx", out_y_idx, '0);
    build_and_fill(r);
    if (step_total != tbl_words[r])
    begin
      $display("row %0d loop model gives %0d words, table says %0d",
               r, step_total, tbl_words[r]);
      report_failure();
    end
    @(negedge clk);
    compare_data("out_data", out_data, '0);
    @(posedge clk);
    conv_store_start <= 1'b1;
    for (int cyc = 1; cyc <= tbl_tile_off[r] + 2; cyc++)
    begin
      @(posedge clk);
      // a second start in the middle of the run
      conv_store_start <= (cyc == 3) && (tbl_words[r] > 4);
      @(negedge clk);
      k = cyc - 2;
      exp_valid = (k >= 0) && (k < tbl_words[r]);
      compare_pulse("out_valid", out_valid, exp_valid);
      compare_pulse("tile_end", tile_end, cyc == tbl_tile_off[r]);
      // busy over the run steps and the one done cycle
      compare_pulse("busy", busy, cyc <= tbl_words[r] + 1);
      if (exp_valid)
        check_word(r, k);
      else
        compare_data("out_data", out_data, '0);
      // pops seen on the read strobes
      for (int i = 0; i < nf; i++)
      begin
        if (conv_store_top_inst.fifo_rd[i])
          model_count[i]--;
      end
    end
    for (int i = 0; i < nf; i++)
    begin
      if (model_count[i] != 0)
      begin
        $display("fifo %0d pops differ from writes by %0d after row %0d",
                 i, model_count[i], r);
        report_failure();
      end
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // main sequence and watchdog
  //////////////////////////////////////////////////////////////////////

  initial
  begin
    void'($urandom(32'hc7a0));
    errors           = 0;
    reset            = 1'b1;
    mode_init        = 1'b0;
    cur_ox_start     = '0;
    cur_oy_start     = '0;
    cur_of_start     = '0;
    cur_pof          = '0;
    cur_poy          = '0;
    conv_store_start = 1'b0;
    fifo_wr_en       = 1'b0;
    fifo_wr_sel      = '0;
    fifo_wr_data     = '0;
    for (int r = 0; r < num_rows; r++)
      run_row(r);
    if (errors == 0)
    begin
      $display("Finished with no errors");
      $finish;
    end
    else
      report_failure();
  end

  initial
  begin
    longint limit;
    limit = 0;
    for (int r = 0; r < num_rows; r++)
    begin
      // tile run plus fill, fill writes at most one word per output
      limit += longint'(tbl_poy[r] * tbl_pof[r] + 20) * period;
      limit += longint'(tbl_poy[r] * tbl_pof[r] + 20) * period;
    end
    #(limit);
    $display("watchdog expired before the test table finished");
    report_failure();
  end

endmodule

`default_nettype wire

/* verilog/conv_store_pkg.sv */
`default_nettype none

package conv_store_pkg;

  ////////////////////////////////////////////////////////////////////
  // state and mode encodings
  ////////////////////////////////////////////////////////////////////

  typedef enum logic [1:0]
  {
    store_idle = 2'd0,
    store_run  = 2'd1,
    store_done = 2'd2
  } store_state_e;

  typedef enum logic
  {
    mode_88 = 1'b0,
    mode_18 = 1'b1
  } store_mode_e;

  ////////////////////////////////////////////////////////////////////
  // fixed loop constants
  ////////////////////////////////////////////////////////////////////

  // systolic array grid, rows set the oy stride in the fifo number
  localparam int sa_grid_rows = 4;
  localparam int sa_grid_cols = 3;
  localparam int fifo_count   = sa_grid_rows * sa_grid_cols;
  localparam int idx_width    = 16;

  // channels per output block, log2 form for the block index
  localparam int block_88_log = 4;
  localparam int block_18_log = 5;

endpackage

`default_nettype wire

/* verilog/conv_store_top.sv */
`timescale 1ns/1ns
`default_nettype none

module conv_store_top
#(
  parameter int column_num  = 4,
  parameter int pixel_width = 8,
  parameter int fifo_depth  = 8
)
(
  input  wire                                               clk,
  input  wire                                               reset,
  input  wire                                               mode_init,
  input  wire [conv_store_pkg::idx_width-1:0]               cur_ox_start,
  input  wire [conv_store_pkg::idx_width-1:0]               cur_oy_start,
  input  wire [conv_store_pkg::idx_width-1:0]               cur_of_start,
  input  wire [conv_store_pkg::idx_width-1:0]               cur_pof,
  input  wire [conv_store_pkg::idx_width-1:0]               cur_poy,
  input  wire                                               conv_store_start,
  input  wire                                               fifo_wr_en,
  input  wire [$clog2(conv_store_pkg::fifo_count)-1:0]      fifo_wr_sel,
  input  wire [pixel_width*4*column_num-1:0]                fifo_wr_data,
  output logic                                              out_valid,
  output logic [conv_store_pkg::idx_width-1:0]              out_y_idx,
  output logic [conv_store_pkg::idx_width-1:0]              out_x_idx,
  output logic [conv_store_pkg::idx_width-1:0]              out_f_idx,
  output logic [$clog2(conv_store_pkg::fifo_count)-1:0]     fifo_row_no,
  output logic [$clog2(conv_store_pkg::fifo_count)-1:0]     fifo_column_no,
  output logic [pixel_width*2*column_num-1:0]               out_data,
  output logic                                              tile_end,
  output logic                                              busy
);

  localparam int iw = conv_store_pkg::idx_width;

  logic                                  run;
  logic                                  last_step;
  logic                                  step_valid;
  logic [conv_store_pkg::fifo_count-1:0] fifo_rd;
  logic [iw-1:0]                         oy_count;
  logic [iw-1:0]                         of_count;
  logic [iw-1:0]                         channel_count;
  conv_store_pkg::store_mode_e           mode;
  logic [pixel_width*4*column_num-1:0]   rd_data;

  store_sequencer store_sequencer_inst
  (
    .clk              (clk),
    .reset            (reset),
    .conv_store_start (conv_store_start),
    .last_step        (last_step),
    .run              (run),
    .tile_end         (tile_end),
    .busy             (busy)
  );

  store_loop_counter #(.column_num(column_num)) store_loop_counter_inst
  (
    .clk           (clk),
    .reset         (reset),
    .mode_init     (mode_init),
    .run           (run),
    .cur_pof       (cur_pof),
    .cur_poy       (cur_poy),
    .last_step     (last_step),
    .step_valid    (step_valid),
    .fifo_rd       (fifo_rd),
    .oy_count      (oy_count),
    .of_count      (of_count),
    .channel_count (channel_count),
    .mode          (mode)
  );

  row_fifo_bank
  #(
    .column_num  (column_num),
    .pixel_width (pixel_width),
    .fifo_depth  (fifo_depth)
  ) row_fifo_bank_inst
  (
    .clk     (clk),
    .reset   (reset),
    .wr_en   (fifo_wr_en),
    .wr_sel  (fifo_wr_sel),
    .wr_data (fifo_wr_data),
    .rd      (fifo_rd),
    .rd_data (rd_data)
  );

  store_output_stage
  #(
    .column_num  (column_num),
    .pixel_width (pixel_width)
  ) store_output_stage_inst
  (
    .clk            (clk),
    .reset          (reset),
    .step_valid     (step_valid),
    .mode           (mode),
    .oy_count       (oy_count),
    .of_count       (of_count),
    .channel_count  (channel_count),
    .cur_ox_start   (cur_ox_start),
    .cur_oy_start   (cur_oy_start),
    .cur_of_start   (cur_of_start),
    .rd_data        (rd_data),
    .out_valid      (out_valid),
    .out_y_idx      (out_y_idx),
    .out_x_idx      (out_x_idx),
    .out_f_idx      (out_f_idx),
    .fifo_row_no    (fifo_row_no),
    .fifo_column_no (fifo_column_no),
    .out_data       (out_data)
  );

endmodule

`default_nettype wire

/* verilog/row_fifo_bank.sv */
`timescale 1ns/1ns
`default_nettype none

module row_fifo_bank
#(
  parameter int column_num  = 4,
  parameter int pixel_width = 8,
  parameter int fifo_depth  = 8
)
(
  input  wire                                                clk,
  input  wire                                                reset,
  input  wire                                                wr_en,
  input  wire [$clog2(conv_store_pkg::fifo_count)-1:0]       wr_sel,
  input  wire [pixel_width*4*column_num-1:0]                 wr_data,
  input  wire [conv_store_pkg::fifo_count-1:0]               rd,
  output logic [pixel_width*4*column_num-1:0]                rd_data
);

  localparam int word_width = pixel_width * 4 * column_num;
  localparam int sel_width  = $clog2(conv_store_pkg::fifo_count);
  localparam int ptr_width  = $clog2(fifo_depth);
  localparam int cnt_width  = $clog2(fifo_depth + 1);

  // word at the read pointer of each fifo
  logic [word_width-1:0] head [conv_store_pkg::fifo_count];

  ////////////////////////////////////////////////////////////////////
  // per fifo circular buffer
  ////////////////////////////////////////////////////////////////////

  for (genvar i = 0; i < conv_store_pkg::fifo_count; i++)
  begin : g_fifo
    logic [word_width-1:0] mem [fifo_depth];
    logic [ptr_width-1:0]  wr_ptr;
    logic [ptr_width-1:0]  rd_ptr;
    logic [cnt_width-1:0]  count;
    logic                  wr_hit;

    assign wr_hit = wr_en && (wr_sel == sel_width'(i));

    always_ff @(posedge clk)
    begin
      if (wr_hit)
        mem[wr_ptr] <= wr_data;
    end

    always_ff @(posedge clk)
    begin
      if (reset)
      begin
        wr_ptr <= '0;
        rd_ptr <= '0;
        count  <= '0;
      end
      else
      begin
        if (wr_hit)
          wr_ptr <= (wr_ptr == ptr_width'(fifo_depth - 1)) ? '0 : wr_ptr + 1'b1;
        if (rd[i])
          rd_ptr <= (rd_ptr == ptr_width'(fifo_depth - 1)) ? '0 : rd_ptr + 1'b1;
        // same cycle write and read leaves count alone
        count <= count + cnt_width'(wr_hit) - cnt_width'(rd[i]);
      end
    end

    assign head[i] = mem[rd_ptr];

    // filler must stay ahead of the store loop
    assert property (@(posedge clk) disable iff (reset)
      rd[i] |-> count != '0);

    assert property (@(posedge clk) disable iff (reset)
      wr_hit |-> count != cnt_width'(fifo_depth));
  end

  ////////////////////////////////////////////////////////////////////
  // registered read port
  ////////////////////////////////////////////////////////////////////

  // holds the last popped word until the next strobe
  always_ff @(posedge clk)
  begin
    for (int i = 0; i < conv_store_pkg::fifo_count; i++)
    begin
      if (rd[i])
        rd_data <= head[i];
    end
  end

endmodule

`default_nettype wire

/* verilog/store_loop_counter.sv */
`timescale 1ns/1ns
`default_nettype none

module store_loop_counter
#(
  parameter int column_num = 4
)
(
  input  wire                                          clk,
  input  wire                                          reset,
  input  wire                                          mode_init,
  input  wire                                          run,
  input  wire [conv_store_pkg::idx_width-1:0]          cur_pof,
  input  wire [conv_store_pkg::idx_width-1:0]          cur_poy,
  output logic                                         last_step,
  output logic                                         step_valid,
  output logic [conv_store_pkg::fifo_count-1:0]        fifo_rd,
  output logic [conv_store_pkg::idx_width-1:0]         oy_count,
  output logic [conv_store_pkg::idx_width-1:0]         of_count,
  output logic [conv_store_pkg::idx_width-1:0]         channel_count,
  output conv_store_pkg::store_mode_e                  mode
);

  localparam int iw = conv_store_pkg::idx_width;

  logic [iw-1:0] block_size;
  logic [iw-1:0] block_log;
  logic [iw-1:0] chan_pos;
  logic [iw-1:0] fifo_num;
  logic          rd_en;
  logic          chan_end;
  logic          of_end;
  logic          oy_end;

  // block sizes below are laid out for these array widths
  if (column_num != 4 && column_num != 16)
  begin : g_bad_column_num
    $error("store_loop_counter: column_num must be 4 or 16");
  end

  // data mode is captured while reset is held
  always_ff @(posedge clk)
  begin
    if (reset)
      mode <= conv_store_pkg::store_mode_e'(mode_init);
  end

  assign block_log  = (mode == conv_store_pkg::mode_88) ?
                      iw'(conv_store_pkg::block_88_log) : iw'(conv_store_pkg::block_18_log);
  assign block_size = iw'(1) << block_log;

  // absolute channel position within the tile, 1 based
  assign chan_pos = of_count + channel_count - iw'(1);

  ////////////////////////////////////////////////////////////////////
  // loop end chain, innermost first
  ////////////////////////////////////////////////////////////////////

  assign chan_end  = run && ((chan_pos == cur_pof) || (channel_count == block_size));
  assign of_end    = chan_end && (chan_pos == cur_pof);
  assign oy_end    = of_end && (oy_count == cur_poy);
  assign last_step = oy_end;

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      channel_count <= iw'(1);
      of_count      <= iw'(1);
      oy_count      <= iw'(1);
    end
    else if (run)
    begin
      channel_count <= chan_end ? iw'(1) : channel_count + iw'(1);
      if (chan_end)
        of_count <= of_end ? iw'(1) : of_count + block_size;
      if (of_end)
        oy_count <= oy_end ? iw'(1) : oy_count + iw'(1);
    end
  end

  ////////////////////////////////////////////////////////////////////
  // fifo selection
  ////////////////////////////////////////////////////////////////////

  // pop every step in 8x8, odd channels only in 1x8
  assign rd_en = run && ((mode == conv_store_pkg::mode_88) || channel_count[0]);

  assign fifo_num = (oy_count - iw'(1)) * iw'(conv_store_pkg::sa_grid_rows)
                    + ((of_count - iw'(1)) >> block_log);

  for (genvar i = 0; i < conv_store_pkg::fifo_count; i++)
  begin : g_rd
    assign fifo_rd[i] = rd_en && (fifo_num == iw'(i));
  end

  assign step_valid = run;

  // a pop step must land on exactly one existing fifo
  assert property (@(posedge clk) disable iff (reset)
    rd_en |-> $onehot(fifo_rd));

endmodule

`default_nettype wire

/* verilog/store_output_stage.sv */
`timescale 1ns/1ns
`default_nettype none

module store_output_stage
#(
  parameter int column_num  = 4,
  parameter int pixel_width = 8
)
(
  input  wire                                               clk,
  input  wire                                               reset,
  input  wire                                               step_valid,
  input  wire conv_store_pkg::store_mode_e                  mode,
  input  wire [conv_store_pkg::idx_width-1:0]               oy_count,
  input  wire [conv_store_pkg::idx_width-1:0]               of_count,
  input  wire [conv_store_pkg::idx_width-1:0]               channel_count,
  input  wire [conv_store_pkg::idx_width-1:0]               cur_ox_start,
  input  wire [conv_store_pkg::idx_width-1:0]               cur_oy_start,
  input  wire [conv_store_pkg::idx_width-1:0]               cur_of_start,
  input  wire [pixel_width*4*column_num-1:0]                rd_data,
  output logic                                              out_valid,
  output logic [conv_store_pkg::idx_width-1:0]              out_y_idx,
  output logic [conv_store_pkg::idx_width-1:0]              out_x_idx,
  output logic [conv_store_pkg::idx_width-1:0]              out_f_idx,
  output logic [$clog2(conv_store_pkg::fifo_count)-1:0]     fifo_row_no,
  output logic [$clog2(conv_store_pkg::fifo_count)-1:0]     fifo_column_no,
  output logic [pixel_width*2*column_num-1:0]               out_data
);

  localparam int iw        = conv_store_pkg::idx_width;
  localparam int no_width  = $clog2(conv_store_pkg::fifo_count);
  localparam int out_width = pixel_width * 2 * column_num;

  logic [iw-1:0] block_log;
  logic          odd_channel;

  assign block_log = (mode == conv_store_pkg::mode_88) ?
                     iw'(conv_store_pkg::block_88_log) : iw'(conv_store_pkg::block_18_log);

  ////////////////////////////////////////////////////////////////////
  // index registers, aligned with rd_data
  ////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      out_valid      <= 1'b0;
      odd_channel    <= 1'b0;
      out_y_idx      <= '0;
      out_x_idx      <= '0;
      out_f_idx      <= '0;
      fifo_row_no    <= '0;
      fifo_column_no <= '0;
    end
    else
    begin
      out_valid <= step_valid;
      if (step_valid)
      begin
        odd_channel    <= channel_count[0];
        out_y_idx      <= cur_oy_start - iw'(1) + oy_count;
        out_x_idx      <= cur_ox_start;
        out_f_idx      <= cur_of_start - iw'(2) + of_count + channel_count;
        fifo_column_no <= no_width'(oy_count - iw'(1));
        fifo_row_no    <= no_width'((of_count - iw'(1)) >> block_log);
      end
    end
  end

  // 1x8 sends low half on the odd channel, high half on the even one
  assign out_data = !out_valid ? '0 :
                    ((mode == conv_store_pkg::mode_88) || odd_channel) ?
                    rd_data[out_width-1:0] : rd_data[2*out_width-1:out_width];

endmodule

`default_nettype wire

/* verilog/store_sequencer.sv */
`timescale 1ns/1ns
`default_nettype none

module store_sequencer
(
  input  wire  clk,
  input  wire  reset,
  input  wire  conv_store_start,
  input  wire  last_step,
  output logic run,
  output logic tile_end,
  output logic busy
);

  conv_store_pkg::store_state_e state;
  conv_store_pkg::store_state_e state_next;

  ////////////////////////////////////////////////////////////////////
  // next state
  ////////////////////////////////////////////////////////////////////

  always_comb
  begin
    state_next = state;
    case (state)
      conv_store_pkg::store_idle:
      begin
        // start only counts here, a pulse while busy is dropped
        if (conv_store_start)
          state_next = conv_store_pkg::store_run;
      end
      conv_store_pkg::store_run:
      begin
        if (last_step)
          state_next = conv_store_pkg::store_done;
      end
      conv_store_pkg::store_done:
      begin
        state_next = conv_store_pkg::store_idle;
      end
      default:
      begin
        state_next = conv_store_pkg::store_idle;
      end
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      state    <= conv_store_pkg::store_idle;
      tile_end <= 1'b0;
    end
    else
    begin
      state    <= state_next;
      // one cycle behind store_done, lines up after the last output word
      tile_end <= (state == conv_store_pkg::store_done);
    end
  end

  // one loop step per cycle while running
  assign run  = (state == conv_store_pkg::store_run);
  assign busy = (state != conv_store_pkg::store_idle);

  ////////////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////////////

  // run must not outlive the final step
  assert property (@(posedge clk) disable iff (reset)
    run && last_step |=> !run ##1 tile_end);

  // tile end only ever follows a final step
  assert property (@(posedge clk) disable iff (reset)
    tile_end |-> $past(run && last_step, 2));

endmodule

`default_nettype wire
